/* build.f */
+incdir+common
common/dot_timing_pkg.sv
common/hires_video_pkg.sv
dot_timing/dot_timing_gen.sv
logic/fetch_delay_line.sv
hires_sequencer/hires_pixel_sequencer.sv
hires_sequencer/hires_video_top.sv
testbench/hires_video_props.sv
testbench/hires_video_checker.sv
testbench/hires_video_tb.sv

/* common/dot_timing_pkg.sv */
`default_nettype none

package dot_timing_pkg;

    // One-hot, one bit per clk_dot4x tick within a dot
    typedef logic [3:0] dot_phase_t;

    // Raster cycle within a line
    typedef logic [6:0] cycle_num_t;

    // Pixel index within a character
    typedef logic [2:0] cycle_bit_t;

    // phi is a level, the others are single-tick pulses
    // fired at the start of each phi half
    typedef struct packed {
        logic phi;
        logic start_dav;
        logic start_pl;
        logic start_10;
    } phase_strobes_t;

endpackage

`default_nettype wire

/* common/hires_consts.svh */
`ifndef HIRES_CONSTS_SVH
`define HIRES_CONSTS_SVH

// Attribute byte bit positions in text mode
`define HIRES_BLNK_BIT 4
`define HIRES_UNDR_BIT 5
`define HIRES_RVRS_BIT 6

// Blink counter bit that gates blinking characters
`define HIRES_BLINK_FREQ 5

// Raster cycles that carry character data
`define VISIBLE_FIRST 15
`define VISIBLE_LAST 54

// Shift stages between fetch and display
`define FETCH_DELAY_DEPTH 5

`define UNDERLINE_ROW 7
`define CYCLES_PER_LINE 63

`endif

/* common/hires_video_pkg.sv */
`default_nettype none

package hires_video_pkg;

    typedef logic [3:0] color_t;
    typedef logic [7:0] pixel_byte_t;
    typedef logic [7:0] attr_t;
    typedef logic [1:0] hires_mode_t;
    typedef logic [2:0] row_t;
    typedef logic [5:0] blink_ctr_t;

    localparam hires_mode_t MODE_TEXT     = 2'd0;
    localparam hires_mode_t MODE_BITMAP2  = 2'd1;
    localparam hires_mode_t MODE_PLANAR16 = 2'd2;
    localparam hires_mode_t MODE_PLANAR4  = 2'd3;

    // One fetched character, attr doubles as second plane in planar modes
    typedef struct packed {
        pixel_byte_t pixels;
        attr_t       attr;
        logic        cursor;
    } char_word_t;

    typedef struct packed {
        logic   active;
        color_t color;
    } sprite_pixel_t;

endpackage

`default_nettype wire

/* dot_timing/dot_timing_gen.sv */
`timescale 1ns/100ps
`default_nettype none

`include "hires_consts.svh"

module dot_timing_gen (
    input  wire                            clk_dot4x,
    input  wire                            rst_n,
    output dot_timing_pkg::dot_phase_t     dot_rising,
    output dot_timing_pkg::phase_strobes_t phase,
    output dot_timing_pkg::cycle_num_t     cycle_num,
    output dot_timing_pkg::cycle_bit_t     hires_cycle_bit
);

    // Tick within the raster cycle, 32 ticks per cycle
    logic [4:0] tick;

    // Outputs are registered decodes of tick, so they lag it by one clock
    always_ff @(posedge clk_dot4x) begin
        if (!rst_n) begin
            tick            <= '0;
            dot_rising      <= '0;
            phase           <= '0;
            cycle_num       <= '0;
            hires_cycle_bit <= '0;
        end else begin
            tick <= tick + 5'd1;

            dot_rising <= dot_timing_pkg::dot_phase_t'(4'b0001 << tick[1:0]);

            phase.phi       <= tick[4];
            phase.start_dav <= (tick[3:0] == 4'd0);
            phase.start_10  <= (tick[3:0] == 4'd10);
            phase.start_pl  <= (tick[3:0] == 4'd14);

            // Pixel steps land on odd ticks, two ticks per pixel index
            hires_cycle_bit <= tick[3:1];

            // dot_rising[3] marks the end of a previous dot, so the first
            // cycle after reset stays at zero
            if (tick == 5'd0 && dot_rising[3]) begin
                if (cycle_num == dot_timing_pkg::cycle_num_t'(`CYCLES_PER_LINE - 1)) begin
                    cycle_num <= '0;
                end else begin
                    cycle_num <= cycle_num + 7'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hires_sequencer/hires_pixel_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "hires_consts.svh"

module hires_pixel_sequencer (
    input  wire                                 clk_dot4x,
    input  wire                                 rst_n,
    input  wire dot_timing_pkg::dot_phase_t     dot_rising,
    input  wire dot_timing_pkg::phase_strobes_t phase,
    input  wire dot_timing_pkg::cycle_num_t     cycle_num,
    input  wire dot_timing_pkg::cycle_bit_t     hires_cycle_bit,
    input  wire hires_video_pkg::char_word_t    aligned_word,
    input  wire dot_timing_pkg::cycle_bit_t     xscroll,
    input  wire hires_video_pkg::color_t        b0c,
    input  wire hires_video_pkg::color_t        ec,
    input  wire                                 main_border,
    input  wire                                 vborder,
    input  wire hires_video_pkg::hires_mode_t   mode,
    input  wire hires_video_pkg::sprite_pixel_t sprite_pixel,
    input  wire hires_video_pkg::blink_ctr_t    blink_ctr,
    input  wire hires_video_pkg::row_t          char_row,
    output hires_video_pkg::color_t             pixel_color,
    output logic                                pixel_strobe
);

    dot_timing_pkg::cycle_num_t  cycle_d0, cycle_d1, cycle_dly;
    dot_timing_pkg::cycle_bit_t  xscroll_d0, xscroll_dly;

    hires_video_pkg::pixel_byte_t pix_shift, pix_src;
    hires_video_pkg::attr_t       attr_shift, attr_src;
    hires_video_pkg::color_t      b0c_s0, ec_s0, next_color, fg;
    logic        cursor_shift, cursor_src;
    logic [1:0]  pix_val, plane2_val;
    logic        visible_now, visible_dly, show;
    logic        step, load, stage0, half_ff, border_s0;
    logic        text_blank, text_undr, text_on;

    assign visible_now = (cycle_num >= dot_timing_pkg::cycle_num_t'(`VISIBLE_FIRST)) &&
                         (cycle_num <= dot_timing_pkg::cycle_num_t'(`VISIBLE_LAST));
    assign visible_dly = (cycle_dly >= dot_timing_pkg::cycle_num_t'(`VISIBLE_FIRST)) &&
                         (cycle_dly <= dot_timing_pkg::cycle_num_t'(`VISIBLE_LAST));

    // Cycle number and scroll follow the fetched data to the display
    always_ff @(posedge clk_dot4x) begin
        if (!rst_n) begin
            cycle_d0    <= '0;
            cycle_d1    <= '0;
            cycle_dly   <= '0;
            xscroll_d0  <= '0;
            xscroll_dly <= '0;
        end else begin
            if (phase.start_dav) begin
                cycle_d0   <= cycle_num;
                cycle_d1   <= cycle_d0;
                xscroll_d0 <= xscroll;
            end
            if (!phase.phi && phase.start_pl) begin
                cycle_dly <= cycle_d1;
                // Scroll only changes while characters are on screen
                if (visible_now && !vborder) begin
                    xscroll_dly <= xscroll_d0;
                end
            end
        end
    end

    assign step = dot_rising[1] | dot_rising[3];
    assign load = step && (xscroll_dly == hires_cycle_bit);
    assign show = visible_dly && !vborder;

    // Shifter source, a fresh character on the scroll position
    always_comb begin
        pix_src    = pix_shift;
        attr_src   = attr_shift;
        cursor_src = cursor_shift;
        if (load) begin
            pix_src    = show ? aligned_word.pixels : '0;
            attr_src   = show ? aligned_word.attr : '0;
            cursor_src = show ? aligned_word.cursor : 1'b0;
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (!rst_n) begin
            stage0       <= 1'b0;
            pixel_strobe <= 1'b0;
            half_ff      <= 1'b0;
        end else begin
            stage0       <= step;
            pixel_strobe <= stage0;
            if (step) begin
                half_ff <= load ? 1'b1 : ~half_ff;
            end
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (step) begin
            border_s0    <= main_border;
            b0c_s0       <= b0c;
            ec_s0        <= ec;
            pix_val      <= pix_src[7:6];
            pix_shift    <= {pix_src[6:0], 1'b0};
            cursor_shift <= cursor_src;
            // Attribute byte is the second plane in planar modes
            if (mode[1]) begin
                plane2_val <= attr_src[7:6];
                attr_shift <= {attr_src[6:0], 1'b0};
            end else begin
                attr_shift <= attr_src;
            end
        end
        if (stage0) begin
            pixel_color <= next_color;
        end
    end

    assign fg         = attr_shift[3:0];
    assign text_blank = attr_shift[`HIRES_BLNK_BIT] && !blink_ctr[`HIRES_BLINK_FREQ];
    assign text_undr  = attr_shift[`HIRES_UNDR_BIT] &&
                        (char_row == hires_video_pkg::row_t'(`UNDERLINE_ROW));
    assign text_on    = pix_val[1] ^ (attr_shift[`HIRES_RVRS_BIT] | cursor_shift);

    // Border over sprite over playfield
    always_comb begin
        if (border_s0) begin
            next_color = ec_s0;
        end else if (sprite_pixel.active) begin
            next_color = sprite_pixel.color;
        end else begin
            case (mode)
                hires_video_pkg::MODE_TEXT:
                    next_color = text_blank ? b0c_s0 :
                                 (text_undr || text_on) ? fg : b0c_s0;
                hires_video_pkg::MODE_BITMAP2:
                    next_color = pix_val[1] ? fg : b0c_s0;
                // Half horizontal rate, each pixel shown twice
                hires_video_pkg::MODE_PLANAR16:
                    next_color = half_ff ? {plane2_val, pix_val} : pixel_color;
                default:
                    next_color = {2'b00, plane2_val[1], pix_val[1]};
            endcase
        end
    end

endmodule

`default_nettype wire

/* hires_sequencer/hires_video_top.sv */
`timescale 1ns/100ps
`default_nettype none

module hires_video_top (
    input  wire                                 clk_dot4x,
    input  wire                                 rst_n,
    input  wire hires_video_pkg::char_word_t    fetch_word,
    input  wire dot_timing_pkg::cycle_bit_t     xscroll,
    input  wire hires_video_pkg::color_t        b0c,
    input  wire hires_video_pkg::color_t        ec,
    input  wire                                 main_border,
    input  wire                                 vborder,
    input  wire hires_video_pkg::hires_mode_t   mode,
    input  wire hires_video_pkg::sprite_pixel_t sprite_pixel,
    input  wire hires_video_pkg::blink_ctr_t    blink_ctr,
    input  wire hires_video_pkg::row_t          char_row,
    output wire hires_video_pkg::color_t        pixel_color,
    output wire                                 pixel_strobe,
    output wire dot_timing_pkg::cycle_num_t     raster_cycle
);

    wire dot_timing_pkg::dot_phase_t     dot_rising;
    wire dot_timing_pkg::phase_strobes_t phase;
    wire dot_timing_pkg::cycle_num_t     cycle_num;
    wire dot_timing_pkg::cycle_bit_t     hires_cycle_bit;
    wire hires_video_pkg::char_word_t    aligned_word;

    assign raster_cycle = cycle_num;

    dot_timing_gen u_timing (
        .clk_dot4x       (clk_dot4x),
        .rst_n           (rst_n),
        .dot_rising      (dot_rising),
        .phase           (phase),
        .cycle_num       (cycle_num),
        .hires_cycle_bit (hires_cycle_bit)
    );

    fetch_delay_line u_delay (
        .clk_dot4x    (clk_dot4x),
        .rst_n        (rst_n),
        .phase        (phase),
        .fetch_word   (fetch_word),
        .aligned_word (aligned_word)
    );

    hires_pixel_sequencer u_seq (
        .clk_dot4x       (clk_dot4x),
        .rst_n           (rst_n),
        .dot_rising      (dot_rising),
        .phase           (phase),
        .cycle_num       (cycle_num),
        .hires_cycle_bit (hires_cycle_bit),
        .aligned_word    (aligned_word),
        .xscroll         (xscroll),
        .b0c             (b0c),
        .ec              (ec),
        .main_border     (main_border),
        .vborder         (vborder),
        .mode            (mode),
        .sprite_pixel    (sprite_pixel),
        .blink_ctr       (blink_ctr),
        .char_row        (char_row),
        .pixel_color     (pixel_color),
        .pixel_strobe    (pixel_strobe)
    );

endmodule

`default_nettype wire

/* logic/fetch_delay_line.sv */
`timescale 1ns/100ps
`default_nettype none

`include "hires_consts.svh"

module fetch_delay_line (
    input  wire                            clk_dot4x,
    input  wire                            rst_n,
    input  wire dot_timing_pkg::phase_strobes_t phase,
    input  wire hires_video_pkg::char_word_t    fetch_word,
    output hires_video_pkg::char_word_t         aligned_word
);

    hires_video_pkg::char_word_t stages [`FETCH_DELAY_DEPTH];

    always_ff @(posedge clk_dot4x) begin
        if (!rst_n) begin
            for (int i = 0; i < `FETCH_DELAY_DEPTH; i++) begin
                stages[i] <= '0;
            end
            aligned_word <= '0;
        end else begin
            // One stage per half cycle
            if (phase.start_10) begin
                stages[0] <= fetch_word;
                for (int i = 1; i < `FETCH_DELAY_DEPTH; i++) begin
                    stages[i] <= stages[i-1];
                end
            end

            // Hold the displayed word for the whole half cycle
            if (phase.start_pl) begin
                aligned_word <= stages[`FETCH_DELAY_DEPTH-1];
            end
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module hires_video_tb -f build.f -o hires_video_sim

status=0
./obj_dir/hires_video_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Something failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation passed"

/* testbench/hires_video_checker.sv */
`timescale 1ns/100ps
`default_nettype none

`include "hires_consts.svh"

module hires_video_checker (
    input  wire                             clk_dot4x,
    input  wire                             rst_n,
    input  wire hires_video_pkg::color_t    pixel_color,
    input  wire                             pixel_strobe,
    input  wire dot_timing_pkg::cycle_num_t raster_cycle,
    input  wire                             measure,
    input  wire [7:0]                       entry_idx,
    input  wire [15:0][3:0]                 exp_hist,
    output int                              error_count
);

    // Stay clear of the window edges, where the pipeline mixes in blank loads
    localparam int FIRST_COUNTED  = `VISIBLE_FIRST + 3;
    localparam int LAST_COUNTED   = `VISIBLE_LAST;
    localparam int COUNTED_PIXELS = (LAST_COUNTED - FIRST_COUNTED + 1) * 16;

    int               color_count [16];
    int               strobe_count;
    logic             measure_q;
    logic             in_window;
    logic [15:0][3:0] hist_q;
    logic [7:0]       idx_q;

    int                         ticks_in_cycle;
    logic                       cycle_seen;
    dot_timing_pkg::cycle_num_t cycle_q;

    assign in_window =
        (raster_cycle >= dot_timing_pkg::cycle_num_t'(FIRST_COUNTED)) &&
        (raster_cycle <= dot_timing_pkg::cycle_num_t'(LAST_COUNTED));

    task automatic compare_counts();
        int want;
        if (strobe_count != COUNTED_PIXELS) begin
            $display("ERROR entry %0d pixel_strobe count: expected %h, got %h",
                     idx_q, COUNTED_PIXELS, strobe_count);
            error_count++;
        end
        for (int c = 0; c < 16; c++) begin
            // Expected counts are given per character of 8 pixels
            want = int'(hist_q[c]) * (COUNTED_PIXELS / 8);
            if (color_count[c] != want) begin
                $display("ERROR entry %0d pixel_color %h count: expected %h, got %h",
                         idx_q, 4'(c), want, color_count[c]);
                error_count++;
            end
        end
    endtask

    // Raster cycle steps by one every 32 ticks and wraps after the last cycle
    task automatic check_raster();
        dot_timing_pkg::cycle_num_t want;
        if (raster_cycle != cycle_q) begin
            if (cycle_q == dot_timing_pkg::cycle_num_t'(`CYCLES_PER_LINE - 1)) begin
                want = '0;
            end else begin
                want = cycle_q + 7'd1;
            end
            if (raster_cycle != want) begin
                $display("ERROR raster_cycle: expected %h, got %h", want, raster_cycle);
                error_count++;
            end
            if (cycle_seen && ticks_in_cycle != 32) begin
                $display("ERROR raster_cycle length in ticks: expected %h, got %h",
                         32, ticks_in_cycle);
                error_count++;
            end
            cycle_seen     = 1'b1;
            ticks_in_cycle = 1;
            cycle_q        = raster_cycle;
        end else begin
            ticks_in_cycle++;
        end
    endtask

    always @(posedge clk_dot4x) begin
        if (!rst_n) begin
            error_count    = 0;
            measure_q      = 1'b0;
            ticks_in_cycle = 0;
            cycle_seen     = 1'b0;
            cycle_q        = '0;
        end else begin
            check_raster();
            if (measure && !measure_q) begin
                for (int c = 0; c < 16; c++) begin
                    color_count[c] = 0;
                end
                strobe_count = 0;
                hist_q       = exp_hist;
                idx_q        = entry_idx;
            end else if (measure && pixel_strobe && in_window) begin
                color_count[pixel_color] += 1;
                strobe_count += 1;
            end
            if (!measure && measure_q) begin
                compare_counts();
            end
            measure_q = measure;
        end
    end

endmodule

`default_nettype wire

/* testbench/hires_video_props.sv */
`timescale 1ns/100ps
`default_nettype none

module hires_video_props (
    input wire                                 clk_dot4x,
    input wire                                 rst_n,
    input wire dot_timing_pkg::phase_strobes_t phase,
    input wire                                 pixel_strobe
);

    // Two pixels per dot, so a strobe is always followed by a gap
    strobe_width: assert property (@(posedge clk_dot4x) disable iff (!rst_n)
        pixel_strobe |=> !pixel_strobe)
        else $error("pixel_strobe high in two adjacent ticks");

    dav_width: assert property (@(posedge clk_dot4x) disable iff (!rst_n)
        phase.start_dav |=> !phase.start_dav)
        else $error("start_dav pulse wider than one tick");

    pl_width: assert property (@(posedge clk_dot4x) disable iff (!rst_n)
        phase.start_pl |=> !phase.start_pl)
        else $error("start_pl pulse wider than one tick");

    ten_width: assert property (@(posedge clk_dot4x) disable iff (!rst_n)
        phase.start_10 |=> !phase.start_10)
        else $error("start_10 pulse wider than one tick");

endmodule

bind hires_pixel_sequencer hires_video_props seq_props (
    .clk_dot4x    (clk_dot4x),
    .rst_n        (rst_n),
    .phase        (phase),
    .pixel_strobe (pixel_strobe)
);

`default_nettype wire

/* testbench/hires_video_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "hires_consts.svh"

module hires_video_tb;

    typedef struct packed {
        hires_video_pkg::hires_mode_t   mode;
        hires_video_pkg::char_word_t    word;
        dot_timing_pkg::cycle_bit_t     xscroll;
        logic                           main_border;
        logic                           vborder;
        hires_video_pkg::sprite_pixel_t sprite;
        hires_video_pkg::blink_ctr_t    blink_ctr;
        hires_video_pkg::row_t          char_row;
        hires_video_pkg::color_t        b0c;
        hires_video_pkg::color_t        ec;
        hires_video_pkg::color_t        exp_fg;
        hires_video_pkg::color_t        exp_bg;
        logic [3:0]                     exp_fg_cnt;
    } stim_entry_t;

    localparam int NUM_ENTRIES    = 14;
    localparam int LINE_TICKS     = `CYCLES_PER_LINE * 32;
    localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 2 * LINE_TICKS + 3 * LINE_TICKS;
    localparam dot_timing_pkg::cycle_num_t LAST_CYCLE =
        dot_timing_pkg::cycle_num_t'(`CYCLES_PER_LINE - 1);

    logic                           clk_dot4x;
    logic                           rst_n;
    hires_video_pkg::char_word_t    fetch_word;
    dot_timing_pkg::cycle_bit_t     xscroll;
    hires_video_pkg::color_t        b0c;
    hires_video_pkg::color_t        ec;
    logic                           main_border;
    logic                           vborder;
    hires_video_pkg::hires_mode_t   mode;
    hires_video_pkg::sprite_pixel_t sprite_pixel;
    hires_video_pkg::blink_ctr_t    blink_ctr;
    hires_video_pkg::row_t          char_row;
    hires_video_pkg::color_t        pixel_color;
    logic                           pixel_strobe;
    dot_timing_pkg::cycle_num_t     raster_cycle;

    logic             measure;
    logic [7:0]       entry_idx;
    logic [15:0][3:0] exp_hist;
    int               error_count;
    int               cycle_count;
    logic [31:0]      rng_state;
    stim_entry_t      stim [NUM_ENTRIES];

    hires_video_top DUT (
        .clk_dot4x    (clk_dot4x),
        .rst_n        (rst_n),
        .fetch_word   (fetch_word),
        .xscroll      (xscroll),
        .b0c          (b0c),
        .ec           (ec),
        .main_border  (main_border),
        .vborder      (vborder),
        .mode         (mode),
        .sprite_pixel (sprite_pixel),
        .blink_ctr    (blink_ctr),
        .char_row     (char_row),
        .pixel_color  (pixel_color),
        .pixel_strobe (pixel_strobe),
        .raster_cycle (raster_cycle)
    );

    hires_video_checker pixel_check (
        .clk_dot4x    (clk_dot4x),
        .rst_n        (rst_n),
        .pixel_color  (pixel_color),
        .pixel_strobe (pixel_strobe),
        .raster_cycle (raster_cycle),
        .measure      (measure),
        .entry_idx    (entry_idx),
        .exp_hist     (exp_hist),
        .error_count  (error_count)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [3:0] count_ones(input logic [7:0] b);
        logic [3:0] n;
        n = 4'd0;
        for (int i = 0; i < 8; i++) begin
            n = n + {3'b000, b[i]};
        end
        return n;
    endfunction

    // Colors per character of 8 pixels
    function automatic logic [15:0][3:0] expected_hist(input stim_entry_t e);
        logic [15:0][3:0] h;
        logic [3:0]       idx;
        h = '0;
        if (e.mode[1] && !e.main_border && !e.sprite.active) begin
            if (e.mode[0]) begin
                // 4-color planar, one bit from each plane
                for (int i = 0; i < 8; i++) begin
                    idx = {2'b00, e.word.attr[i], e.word.pixels[i]};
                    h[idx] = h[idx] + 4'd1;
                end
            end else begin
                // 16-color planar, bit pairs joined and shown twice
                for (int j = 0; j < 4; j++) begin
                    idx = {e.word.attr[2*j +: 2], e.word.pixels[2*j +: 2]};
                    h[idx] = h[idx] + 4'd2;
                end
            end
        end else begin
            h[e.exp_fg] = h[e.exp_fg] + e.exp_fg_cnt;
            h[e.exp_bg] = h[e.exp_bg] + (4'd8 - e.exp_fg_cnt);
        end
        return h;
    endfunction

    task automatic set_entry(
        input int                             idx,
        input hires_video_pkg::hires_mode_t   mode_v,
        input hires_video_pkg::pixel_byte_t   pixels,
        input hires_video_pkg::attr_t         attr,
        input logic                           cursor,
        input dot_timing_pkg::cycle_bit_t     xs,
        input logic                           border,
        input logic                           vb,
        input hires_video_pkg::sprite_pixel_t spr,
        input hires_video_pkg::blink_ctr_t    blink,
        input hires_video_pkg::row_t          row,
        input hires_video_pkg::color_t        b0c_v,
        input hires_video_pkg::color_t        ec_v,
        input hires_video_pkg::color_t        fg,
        input hires_video_pkg::color_t        bg,
        input logic [3:0]                     fg_cnt
    );
        stim[idx] = {mode_v, pixels, attr, cursor, xs, border, vb, spr, blink, row,
                     b0c_v, ec_v, fg, bg, fg_cnt};
    endtask

    task automatic build_stim();
        hires_video_pkg::pixel_byte_t rnd_a;
        hires_video_pkg::pixel_byte_t rnd_b;
        hires_video_pkg::pixel_byte_t rnd_c;
        hires_video_pkg::attr_t       rnd_d;
        // Border, then sprite over bitmap
        set_entry(0, 2'd0, 8'hA5, 8'h03, 1'b0, 3'd0, 1'b1, 1'b0, 5'h00, 6'h20, 3'd0,
                  4'h6, 4'hE, 4'hE, 4'hE, 4'd8);
        set_entry(1, 2'd1, 8'h3C, 8'h05, 1'b0, 3'd2, 1'b0, 1'b0, 5'h19, 6'h20, 3'd0,
                  4'h6, 4'hE, 4'h9, 4'h9, 4'd8);
        // Text plain, reverse, cursor, underline, blink
        set_entry(2, 2'd0, 8'hA5, 8'h02, 1'b0, 3'd3, 1'b0, 1'b0, 5'h00, 6'h20, 3'd0,
                  4'h6, 4'hE, 4'h2, 4'h6, 4'd4);
        set_entry(3, 2'd0, 8'hE0, 8'h41, 1'b0, 3'd0, 1'b0, 1'b0, 5'h00, 6'h20, 3'd0,
                  4'h6, 4'hE, 4'h1, 4'h6, 4'd5);
        set_entry(4, 2'd0, 8'h81, 8'h07, 1'b1, 3'd6, 1'b0, 1'b0, 5'h00, 6'h20, 3'd0,
                  4'h6, 4'hE, 4'h7, 4'h6, 4'd6);
        set_entry(5, 2'd0, 8'h10, 8'h25, 1'b0, 3'd1, 1'b0, 1'b0, 5'h00, 6'h20, 3'd7,
                  4'h6, 4'hE, 4'h5, 4'h6, 4'd8);
        set_entry(6, 2'd0, 8'hFF, 8'h1B, 1'b0, 3'd0, 1'b0, 1'b0, 5'h00, 6'h1F, 3'd0,
                  4'h3, 4'hE, 4'hB, 4'h3, 4'd0);
        // Vertical border blanks the characters to b0c
        set_entry(7, 2'd0, 8'hFF, 8'h0C, 1'b0, 3'd0, 1'b0, 1'b1, 5'h00, 6'h20, 3'd0,
                  4'h6, 4'hE, 4'hC, 4'h6, 4'd0);
        set_entry(8, 2'd1, 8'hF1, 8'h0D, 1'b0, 3'd5, 1'b0, 1'b0, 5'h00, 6'h20, 3'd0,
                  4'h6, 4'hE, 4'hD, 4'h6, 4'd5);
        // Planar modes take their colors from the bytes
        set_entry(9, 2'd3, 8'hCC, 8'hAA, 1'b0, 3'd0, 1'b0, 1'b0, 5'h00, 6'h20, 3'd0,
                  4'h6, 4'hE, 4'h0, 4'h0, 4'd0);
        set_entry(10, 2'd2, 8'h1B, 8'hE4, 1'b0, 3'd4, 1'b0, 1'b0, 5'h00, 6'h20, 3'd0,
                  4'h6, 4'hE, 4'h0, 4'h0, 4'd0);
        rng_state = xorshift32(rng_state);
        rnd_a = rng_state[7:0];
        rng_state = xorshift32(rng_state);
        rnd_b = rng_state[7:0];
        rng_state = xorshift32(rng_state);
        rnd_c = rng_state[7:0];
        rnd_d = rng_state[15:8];
        set_entry(11, 2'd0, rnd_a, 8'h0A, 1'b0, 3'd2, 1'b0, 1'b0, 5'h00, 6'h20, 3'd0,
                  4'h6, 4'hE, 4'hA, 4'h6, count_ones(rnd_a));
        set_entry(12, 2'd1, rnd_b, 8'h03, 1'b0, 3'd7, 1'b0, 1'b0, 5'h00, 6'h20, 3'd0,
                  4'h8, 4'hE, 4'h3, 4'h8, count_ones(rnd_b));
        set_entry(13, 2'd3, rnd_c, rnd_d, 1'b0, 3'd1, 1'b0, 1'b0, 5'h00, 6'h20, 3'd0,
                  4'h6, 4'hE, 4'h0, 4'h0, 4'd0);
    endtask

    task automatic apply_entry(input int i);
        mode         = stim[i].mode;
        fetch_word   = stim[i].word;
        xscroll      = stim[i].xscroll;
        main_border  = stim[i].main_border;
        vborder      = stim[i].vborder;
        sprite_pixel = stim[i].sprite;
        blink_ctr    = stim[i].blink_ctr;
        char_row     = stim[i].char_row;
        b0c          = stim[i].b0c;
        ec           = stim[i].ec;
        exp_hist     = expected_hist(stim[i]);
        entry_idx    = 8'(i);
    endtask

    // Returns 1 ns after the edge where a new line begins
    task automatic wait_line_start();
        @(posedge clk_dot4x);
        while (raster_cycle != LAST_CYCLE) @(posedge clk_dot4x);
        while (raster_cycle != '0) @(posedge clk_dot4x);
        #1;
    endtask

    initial begin
        clk_dot4x = 1'b0;
        forever #2 clk_dot4x = ~clk_dot4x;
    end

    initial begin : timeout_watch
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_dot4x);
            cycle_count++;
        end
        $display("Timeout after %0d clock cycles, the entries did not all finish",
                 cycle_count);
        $display("Something failed");
        $finish;
    end

    initial begin : run_tests
        rst_n        = 1'b0;
        fetch_word   = '0;
        xscroll      = '0;
        b0c          = '0;
        ec           = '0;
        main_border  = 1'b0;
        vborder      = 1'b0;
        mode         = '0;
        sprite_pixel = '0;
        blink_ctr    = '0;
        char_row     = '0;
        measure      = 1'b0;
        entry_idx    = '0;
        exp_hist     = '0;
        rng_state    = 32'd96945;
        build_stim();
        repeat (2) @(posedge clk_dot4x);
        #1;
        rst_n = 1'b1;
        // First line of an entry fills the pipeline, the second is measured
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            apply_entry(i);
            wait_line_start();
            measure = 1'b1;
            wait_line_start();
            measure = 1'b0;
        end
        repeat (4) @(posedge clk_dot4x);
        $display("Run complete: %0d entries, %0d errors", NUM_ENTRIES, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
